//--- processor.f
hw/cpu_isa_pkg.sv
hw/cpu_pipe_pkg.sv
hw/instr_fetch.sv
hw/reg_bank.sv
hw/exec_mem.sv
hw/processor.sv
verification/processor_properties.sv
verification/processor_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the processor testbench with Verilator and run it.
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module processor_tb \
	-f processor.f -o processor_sim

# The simulator exit code is not used, the log decides.
./obj_dir/processor_sim | tee sim.log

if grep -q "Result: FAILED" sim.log; then
	echo "Simulation failed."
	exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
	echo "Simulation ended without a result."
	exit 1
fi
echo "Simulation passed."

//--- verification/processor_tb.sv
`timescale 1ns/1ps

module processor_tb
	import cpu_isa_pkg::*;
();

	typedef struct packed {
		reg_idx_t idx;
		word_t    data;
	} wb_entry_t;

	typedef struct packed {
		dmem_addr_t addr;
		word_t      data;
	} st_entry_t;

	logic       CLK;
	logic       arst_n;
	logic       run;
	logic       im_we;
	word_t      im_data;
	logic       wb_valid;
	reg_idx_t   wb_reg;
	word_t      wb_data;
	logic       st_valid;
	dmem_addr_t st_addr;
	word_t      st_data;
	logic       halted;

	word_t       prog [IMEM_DEPTH];
	int          prog_len;
	logic [31:0] lfsr_state;
	wb_entry_t   exp_wb_q [$];
	st_entry_t   exp_st_q [$];
	int          wb_count = 0;
	int          st_count = 0;
	int          cycle_count;
	int          cycle_limit;

	processor processor_inst (
		.CLK      (CLK),
		.arst_n   (arst_n),
		.run      (run),
		.im_we    (im_we),
		.im_data  (im_data),
		.wb_valid (wb_valid),
		.wb_reg   (wb_reg),
		.wb_data  (wb_data),
		.st_valid (st_valid),
		.st_addr  (st_addr),
		.st_data  (st_data),
		.halted   (halted)
	);

	bind processor processor_properties processor_properties_inst (
		.CLK      (CLK),
		.arst_n   (arst_n),
		.run      (run),
		.wb_valid (wb_valid),
		.st_valid (st_valid),
		.halted   (halted)
	);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	// ************************************************************
	// Random fields and program construction.
	// ************************************************************

	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] draw_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		return v;
	endfunction

	function automatic reg_idx_t rand_reg();
		return reg_idx_t'(draw_bits(4));
	endfunction

	function automatic imm_t rand_imm();
		return imm_t'(draw_bits(16));
	endfunction

	task automatic put(opcode_t op, reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2, imm_t imm);
		word_t w;
		w = '0;
		w[OP_MSB:OP_LSB]   = op;
		w[RD_MSB:RD_LSB]   = rd;
		w[RS1_MSB:RS1_LSB] = rs1;
		w[RS2_MSB:RS2_LSB] = rs2;
		w[IMM_MSB:IMM_LSB] = imm;
		prog[prog_len] = w;
		prog_len++;
	endtask

	// Forward branch over two slots, the first one is the flushed slot.
	task automatic put_branch(opcode_t op);
		put(op, 4'd0, 4'd0, 4'd0, imm_t'(2 + draw_bits(1)));
		put(OP_ST, 4'd0, rand_reg(), rand_reg(), rand_imm());
		put(OP_ADDI, rand_reg(), rand_reg(), 4'd0, rand_imm());
	endtask

	task automatic build_program();
		reg_idx_t ra;
		reg_idx_t rb;
		reg_idx_t rc;
		imm_t     off;
		prog_len = 0;
		repeat (4) put(OP_ADDI, rand_reg(), rand_reg(), 4'd0, rand_imm());
		put(OP_ADD, rand_reg(), rand_reg(), rand_reg(), '0);
		put(OP_SUB, rand_reg(), rand_reg(), rand_reg(), '0);
		put(OP_AND, rand_reg(), rand_reg(), rand_reg(), '0);
		put(OP_OR, rand_reg(), rand_reg(), rand_reg(), '0);
		put(OP_XOR, rand_reg(), rand_reg(), rand_reg(), '0);
		// Dependencies at distance one and two.
		ra = rand_reg();
		rb = rand_reg();
		rc = rand_reg();
		put(OP_ADDI, ra, rb, 4'd0, rand_imm());
		put(OP_ADD, rb, ra, ra, '0);
		put(OP_SUB, rc, ra, rb, '0);
		repeat (2) begin
			ra  = rand_reg();
			rb  = rand_reg();
			rc  = rand_reg();
			off = rand_imm();
			put(OP_ST, 4'd0, ra, rb, off);
			put(OP_LD, rc, ra, 4'd0, off);
			put(OP_XOR, rand_reg(), rc, rb, '0);
		end
		// Equal compare, then a compare of rb = ra + 1.
		for (int i = 0; i < 2; i++) begin
			ra = rand_reg();
			rb = ra ^ 4'd1;
			put(OP_CMP, 4'd0, ra, ra, '0);
			put_branch(i ? OP_BNZ : OP_BZ);
			put(OP_ADDI, rb, ra, 4'd0, 16'sd1);
			put(OP_CMP, 4'd0, rb, ra, '0);
			put_branch(i ? OP_BZ : OP_BNZ);
		end
		put(OP_ADD, rand_reg(), rand_reg(), rand_reg(), '0);
		put(OP_HALT, 4'd0, 4'd0, 4'd0, '0);
	endtask

	// ************************************************************
	// Reference model of the instruction set.
	// ************************************************************

	function automatic int run_reference();
		word_t      regs [NUM_REGS];
		word_t      dmem [DMEM_DEPTH];
		logic       zero;
		imem_addr_t pc;
		imem_addr_t next_pc;
		int         executed;
		word_t      instr;
		word_t      a;
		word_t      b;
		word_t      imm;
		word_t      sum;
		opcode_t    op;
		wb_entry_t  wb_exp;
		st_entry_t  st_exp;
		zero     = 1'b0;
		pc       = '0;
		executed = 0;
		op       = OP_ADD;
		foreach (regs[i]) regs[i] = '0;
		foreach (dmem[i]) dmem[i] = '0;
		while (op != OP_HALT && executed < 1000) begin
			instr   = prog[pc];
			op      = opcode_t'(instr[OP_MSB:OP_LSB]);
			a       = regs[instr[RS1_MSB:RS1_LSB]];
			b       = regs[instr[RS2_MSB:RS2_LSB]];
			imm     = {{16{instr[IMM_MSB]}}, instr[IMM_MSB:IMM_LSB]};
			sum     = a + imm;
			next_pc = pc + imem_addr_t'(1);
			wb_exp.idx  = instr[RD_MSB:RD_LSB];
			wb_exp.data = '0;
			executed++;
			case (op)
				OP_ADD:  wb_exp.data = a + b;
				OP_SUB:  wb_exp.data = a - b;
				OP_AND:  wb_exp.data = a & b;
				OP_OR:   wb_exp.data = a | b;
				OP_XOR:  wb_exp.data = a ^ b;
				OP_ADDI: wb_exp.data = sum;
				OP_LD:   wb_exp.data = dmem[sum[5:0]];
				OP_ST: begin
					st_exp.addr = sum[5:0];
					st_exp.data = b;
					dmem[st_exp.addr] = b;
					exp_st_q.push_back(st_exp);
				end
				OP_CMP:  zero = ((a - b) == '0);
				OP_BZ:   if (zero) next_pc = pc + imm[5:0];
				OP_BNZ:  if (!zero) next_pc = pc + imm[5:0];
				default: ;
			endcase
			if (op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_LD}) begin
				regs[wb_exp.idx] = wb_exp.data;
				exp_wb_q.push_back(wb_exp);
			end
			pc = next_pc;
		end
		return executed;
	endfunction

	// ************************************************************
	// Checks.
	// ************************************************************

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1, "Simulation stopped at the first error.");
	endtask

	task automatic check_wb(string name, reg_idx_t exp_reg, word_t exp_data,
		reg_idx_t act_reg, word_t act_data);
		if (act_reg !== exp_reg || act_data !== exp_data) begin
			$display("MISMATCH %s expected r%0d=0x%08h actual r%0d=0x%08h",
				name, exp_reg, exp_data, act_reg, act_data);
			stop_with_failure("Register writeback differs from the reference model.");
		end
	endtask

	task automatic check_store(string name, dmem_addr_t exp_addr, word_t exp_data,
		dmem_addr_t act_addr, word_t act_data);
		if (act_addr !== exp_addr || act_data !== exp_data) begin
			$display("MISMATCH %s expected [%0d]=0x%08h actual [%0d]=0x%08h",
				name, exp_addr, exp_data, act_addr, act_data);
			stop_with_failure("Store differs from the reference model.");
		end
	endtask

	// Outputs come from the WB register, so they are stable at the falling edge.
	always @(negedge CLK) begin : compare_results
		wb_entry_t exp_wb;
		st_entry_t exp_st;
		if (arst_n && wb_valid) begin
			if (exp_wb_q.size() == 0) begin
				stop_with_failure("A register writeback appeared with none left to expect.");
			end else begin
				exp_wb = exp_wb_q.pop_front();
				check_wb($sformatf("writeback %0d", wb_count), exp_wb.idx, exp_wb.data,
					wb_reg, wb_data);
				wb_count++;
			end
		end
		if (arst_n && st_valid) begin
			if (exp_st_q.size() == 0) begin
				stop_with_failure("A store appeared with none left to expect.");
			end else begin
				exp_st = exp_st_q.pop_front();
				check_store($sformatf("store %0d", st_count), exp_st.addr, exp_st.data,
					st_addr, st_data);
				st_count++;
			end
		end
	end

	always @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			cycle_count <= 0;
		end else if (cycle_count >= cycle_limit) begin
			stop_with_failure($sformatf("Timeout after %0d cycles without reaching HALT.",
				cycle_limit));
		end else begin
			cycle_count <= cycle_count + 1;
		end
	end

	// ************************************************************
	// Stimulus.
	// ************************************************************

	task automatic load_program();
		for (int i = 0; i < prog_len; i++) begin
			@(posedge CLK);
			im_we   <= 1'b1;
			im_data <= prog[i];
		end
		@(posedge CLK);
		im_we   <= 1'b0;
		im_data <= '0;
	endtask

	initial begin
		int executed;
		arst_n     = 1'b0;
		run        = 1'b0;
		im_we      = 1'b0;
		im_data    = '0;
		lfsr_state = 32'd32;
		build_program();
		executed    = run_reference();
		cycle_limit = 4 * executed + prog_len + 50;
		repeat (3) @(posedge CLK);
		arst_n <= 1'b1;
		load_program();
		@(posedge CLK);
		run <= 1'b1;
		wait (halted);
		if (exp_wb_q.size() != 0 || exp_st_q.size() != 0) begin
			stop_with_failure("halted rose before every expected result was seen.");
		end else begin
			// Late strobes would be caught by the compare process.
			repeat (4) @(posedge CLK);
			$display("Result: PASSED");
			$finish;
		end
	end

endmodule

//--- verification/processor_properties.sv
`timescale 1ns/1ps

module processor_properties (
	input logic CLK,
	input logic arst_n,
	input logic run,
	input logic wb_valid,
	input logic st_valid,
	input logic halted
);

	// A retired instruction either writes a register or stores, never both.
	one_strobe_a: assert property (@(posedge CLK) disable iff (!arst_n)
		!(wb_valid && st_valid))
		else $error("wb_valid and st_valid are high in the same cycle");

	// Nothing retires while the core is still loading.
	quiet_before_run_a: assert property (@(posedge CLK) disable iff (!arst_n)
		!run |-> !(wb_valid || st_valid || halted))
		else $error("output strobe seen before run was raised");

	halted_sticky_a: assert property (@(posedge CLK) disable iff (!arst_n)
		halted |=> halted)
		else $error("halted fell after it was raised");

	no_wb_after_halt_a: assert property (@(posedge CLK) disable iff (!arst_n)
		halted |-> !wb_valid)
		else $error("register writeback seen after halted");

endmodule

//--- hw/processor.sv
`timescale 1ns/1ps

module processor
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;
(
	input  logic       CLK,
	input  logic       arst_n,
	input  logic       run,
	input  logic       im_we,
	input  word_t      im_data,
	output logic       wb_valid,
	output reg_idx_t   wb_reg,
	output word_t      wb_data,
	output logic       st_valid,
	output dmem_addr_t st_addr,
	output word_t      st_data,
	output logic       halted
);

	ifid_exmem_t ifid;
	exmem_wb_t   wb;
	reg_idx_t    rd_idx_a;
	reg_idx_t    rd_idx_b;
	word_t       rd_data_a;
	word_t       rd_data_b;
	logic        redirect;
	imem_addr_t  redirect_pc;
	logic        rb_wr_en;

	assign rb_wr_en = wb.valid && wb.wr_reg;

	instr_fetch instr_fetch_inst (
		.CLK         (CLK),
		.arst_n      (arst_n),
		.run         (run),
		.im_we       (im_we),
		.im_data     (im_data),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.rd_idx_a    (rd_idx_a),
		.rd_idx_b    (rd_idx_b),
		.rd_data_a   (rd_data_a),
		.rd_data_b   (rd_data_b),
		.ifid        (ifid)
	);

	reg_bank reg_bank_inst (
		.CLK       (CLK),
		.arst_n    (arst_n),
		.rd_idx_a  (rd_idx_a),
		.rd_idx_b  (rd_idx_b),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b),
		.wr_en     (rb_wr_en),
		.wr_idx    (wb.rd),
		.wr_data   (wb.result)
	);

	exec_mem exec_mem_inst (
		.CLK         (CLK),
		.arst_n      (arst_n),
		.ifid        (ifid),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.wb          (wb)
	);

	// Observation ports.
	assign wb_valid = rb_wr_en;
	assign wb_reg   = wb.rd;
	assign wb_data  = wb.result;
	assign st_valid = wb.valid && wb.store;
	assign st_addr  = wb.st_addr;
	assign st_data  = wb.st_data;
	assign halted   = wb.halt;

endmodule

//--- hw/exec_mem.sv
`timescale 1ns/1ps

module exec_mem
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;
(
	input  logic        CLK,
	input  logic        arst_n,
	input  ifid_exmem_t ifid,
	output logic        redirect,
	output imem_addr_t  redirect_pc,
	output exmem_wb_t   wb
);

	word_t      dmem [DMEM_DEPTH];
	flags_t     flags;

	word_t      op_a;
	word_t      op_b;
	word_t      addr_sum;
	word_t      cmp_diff;
	word_t      alu_res;
	dmem_addr_t mem_addr;
	logic       writes_reg;
	logic       taken;

	// ************************************************************
	// Operand forwarding from the WB register.
	// ************************************************************

	assign op_a = (wb.valid && wb.wr_reg && wb.rd == ifid.rs1) ? wb.result : ifid.rs1_data;
	assign op_b = (wb.valid && wb.wr_reg && wb.rd == ifid.rs2) ? wb.result : ifid.rs2_data;

	assign addr_sum = op_a + ifid.imm;
	assign mem_addr = addr_sum[$bits(dmem_addr_t)-1:0];
	assign cmp_diff = op_a - op_b;

	always_comb begin
		case (ifid.op)
			OP_ADD:  alu_res = op_a + op_b;
			OP_SUB:  alu_res = cmp_diff;
			OP_AND:  alu_res = op_a & op_b;
			OP_OR:   alu_res = op_a | op_b;
			OP_XOR:  alu_res = op_a ^ op_b;
			OP_ADDI: alu_res = addr_sum;
			OP_LD:   alu_res = dmem[mem_addr];
			default: alu_res = '0;
		endcase
	end

	assign writes_reg = ifid.op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_LD};

	// Flags set by CMP, read by the next branch.
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			flags <= '0;
		end else if (ifid.valid && ifid.op == OP_CMP) begin
			flags[FLAG_Z] <= (cmp_diff == '0);
			flags[FLAG_N] <= cmp_diff[31];
		end
	end

	always_comb begin
		case (ifid.op)
			OP_BZ:   taken = flags[FLAG_Z];
			OP_BNZ:  taken = !flags[FLAG_Z];
			default: taken = 1'b0;
		endcase
	end

	assign redirect    = ifid.valid && taken;
	assign redirect_pc = ifid.pc + ifid.imm[$bits(imem_addr_t)-1:0];

	// ************************************************************
	// Data memory and WB register.
	// ************************************************************

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < DMEM_DEPTH; i++) begin
				dmem[i] <= '0;
			end
		end else if (ifid.valid && ifid.op == OP_ST) begin
			dmem[mem_addr] <= op_b;
		end
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			wb <= '0;
		end else begin
			wb.valid   <= ifid.valid;
			wb.wr_reg  <= writes_reg;
			wb.rd      <= ifid.rd;
			wb.result  <= alu_res;
			wb.store   <= (ifid.op == OP_ST);
			wb.st_addr <= mem_addr;
			wb.st_data <= op_b;
			// Sticky, it marks the end of the program.
			wb.halt    <= wb.halt || (ifid.valid && ifid.op == OP_HALT);
		end
	end

endmodule

//--- hw/reg_bank.sv
`timescale 1ns/1ps

module reg_bank
	import cpu_isa_pkg::*;
(
	input  logic     CLK,
	input  logic     arst_n,
	input  reg_idx_t rd_idx_a,
	input  reg_idx_t rd_idx_b,
	output word_t    rd_data_a,
	output word_t    rd_data_b,
	input  logic     wr_en,
	input  reg_idx_t wr_idx,
	input  word_t    wr_data
);

	word_t regs [NUM_REGS];

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// Write-through, so a same-cycle read sees the new value.
	assign rd_data_a = (wr_en && wr_idx == rd_idx_a) ? wr_data : regs[rd_idx_a];
	assign rd_data_b = (wr_en && wr_idx == rd_idx_b) ? wr_data : regs[rd_idx_b];

endmodule

//--- hw/instr_fetch.sv
`timescale 1ns/1ps

module instr_fetch
	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;
(
	input  logic        CLK,
	input  logic        arst_n,
	input  logic        run,
	input  logic        im_we,
	input  word_t       im_data,
	input  logic        redirect,
	input  imem_addr_t  redirect_pc,
	output reg_idx_t    rd_idx_a,
	output reg_idx_t    rd_idx_b,
	input  word_t       rd_data_a,
	input  word_t       rd_data_b,
	output ifid_exmem_t ifid
);

	word_t        imem [IMEM_DEPTH];
	imem_addr_t   load_addr;
	imem_addr_t   pc;
	fetch_state_t state;

	word_t    instr;
	opcode_t  op;
	imm_t     imm;
	word_t    imm_ext;
	logic     load_we;
	logic     slot_valid;

	assign load_we = im_we && (state == LOAD);

	// Program loading, one word per strobe.
	always_ff @(posedge CLK) begin
		if (load_we) begin
			imem[load_addr] <= im_data;
		end
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			load_addr <= '0;
		end else if (load_we) begin
			load_addr <= load_addr + imem_addr_t'(1);
		end
	end

	// ************************************************************
	// Fetch and decode.
	// ************************************************************

	assign instr    = imem[pc];
	assign op       = opcode_t'(instr[OP_MSB:OP_LSB]);
	assign rd_idx_a = instr[RS1_MSB:RS1_LSB];
	assign rd_idx_b = instr[RS2_MSB:RS2_LSB];
	assign imm      = instr[IMM_MSB:IMM_LSB];
	assign imm_ext  = {{16{imm[15]}}, imm};

	// A redirect flushes whatever is fetched in the same cycle.
	assign slot_valid = (state == RUN) && !redirect;

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			state <= LOAD;
			pc    <= '0;
		end else begin
			case (state)
				LOAD: begin
					if (run) begin
						state <= RUN;
						pc    <= '0;
					end
				end
				RUN: begin
					if (redirect) begin
						pc <= redirect_pc;
					end else begin
						pc <= pc + imem_addr_t'(1);
						if (op == OP_HALT) begin
							state <= DONE;
						end
					end
				end
				default: begin
					state <= DONE;
				end
			endcase
		end
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			ifid <= '0;
		end else begin
			ifid.valid    <= slot_valid;
			ifid.op       <= op;
			ifid.rd       <= instr[RD_MSB:RD_LSB];
			ifid.rs1      <= rd_idx_a;
			ifid.rs2      <= rd_idx_b;
			ifid.rs1_data <= rd_data_a;
			ifid.rs2_data <= rd_data_b;
			ifid.imm      <= imm_ext;
			ifid.pc       <= pc;
		end
	end

endmodule

//--- hw/cpu_pipe_pkg.sv
package cpu_pipe_pkg;

	import cpu_isa_pkg::*;

	// ************************************************************
	// Pipeline registers.
	// ************************************************************

	// Decoded instruction with its operands, IF/ID to EX/MEM.
	typedef struct packed {
		logic       valid;
		opcode_t    op;
		reg_idx_t   rd;
		reg_idx_t   rs1;
		reg_idx_t   rs2;
		word_t      rs1_data;
		word_t      rs2_data;
		word_t      imm;
		imem_addr_t pc;
	} ifid_exmem_t;

	// Retired instruction, EX/MEM to WB.
	typedef struct packed {
		logic       valid;
		logic       wr_reg;
		reg_idx_t   rd;
		word_t      result;
		logic       store;
		dmem_addr_t st_addr;
		word_t      st_data;
		logic       halt;
	} exmem_wb_t;

	typedef enum logic [1:0] {
		LOAD,
		RUN,
		DONE
	} fetch_state_t;

endpackage

//--- hw/cpu_isa_pkg.sv
package cpu_isa_pkg;

	// ************************************************************
	// Word and field types.
	// ************************************************************

	typedef logic [31:0]        word_t;
	typedef logic [3:0]         reg_idx_t;
	typedef logic [5:0]         imem_addr_t;
	typedef logic [5:0]         dmem_addr_t;
	typedef logic signed [15:0] imm_t;

	// Z in bit 1, N in bit 0.
	typedef logic [1:0] flags_t;

	localparam int FLAG_Z = 1;
	localparam int FLAG_N = 0;

	localparam int NUM_REGS   = 16;
	localparam int IMEM_DEPTH = 64;
	localparam int DMEM_DEPTH = 64;

	typedef enum logic [3:0] {
		OP_ADD  = 4'd0,
		OP_SUB  = 4'd1,
		OP_AND  = 4'd2,
		OP_OR   = 4'd3,
		OP_XOR  = 4'd4,
		OP_ADDI = 4'd5,
		OP_LD   = 4'd6,
		OP_ST   = 4'd7,
		OP_CMP  = 4'd8,
		OP_BZ   = 4'd9,
		OP_BNZ  = 4'd10,
		OP_HALT = 4'd11
	} opcode_t;

	// Instruction layout, op | rd | rs1 | rs2 | imm.
	localparam int OP_MSB  = 31;
	localparam int OP_LSB  = 28;
	localparam int RD_MSB  = 27;
	localparam int RD_LSB  = 24;
	localparam int RS1_MSB = 23;
	localparam int RS1_LSB = 20;
	localparam int RS2_MSB = 19;
	localparam int RS2_LSB = 16;
	localparam int IMM_MSB = 15;
	localparam int IMM_LSB = 0;

endpackage
